//--- all.f
core_pkg.sv
fetch_pkg.sv
bp_if.sv
fetch_queue.sv
branch_predictor.sv
fetch.sv
fetch_top.sv
fetch_top_properties.sv
tb_fetch_top.sv

//--- tb_fetch_top.sv
// Fetch stage testbench
`timescale 1ns/1ps

module tb_fetch_top;
	import core_pkg::*;
	import fetch_pkg::*;

	localparam int NUM_ROWS   = 5;
	localparam int BP_ENTRIES = 8;
	localparam int IDX_W      = $clog2(BP_ENTRIES);

	logic                   iCLOCK = 1'b0;
	logic                   inRESET;
	logic [31:0]            iSYSREG_PSR;
	logic                   iEXCEPTION_EVENT;
	logic                   iEXCEPTION_ADDR_SET;
	logic [31:0]            iEXCEPTION_ADDR;
	logic                   oPREVIOUS_FETCH_REQ;
	logic                   iPREVIOUS_FETCH_LOCK;
	logic [1:0]             oPREVIOUS_MMUMOD;
	logic [31:0]            oPREVIOUS_FETCH_ADDR;
	logic                   iPREVIOUS_INST_VALID;
	logic [31:0]            iPREVIOUS_INST;
	logic                   iPREVIOUS_PAGEFAULT;
	logic [MMU_FLAGS_W-1:0] iPREVIOUS_MMU_FLAGS;
	logic                   oPREVIOUS_LOCK;
	logic                   oNEXT_INST_VALID;
	logic [31:0]            oNEXT_INST;
	logic                   oNEXT_PAGEFAULT;
	logic [MMU_FLAGS_W-1:0] oNEXT_MMU_FLAGS;
	logic                   oNEXT_PAGING_ENA;
	logic                   oNEXT_KERNEL_ACCESS;
	logic [31:0]            oNEXT_PC;
	logic                   oNEXT_BRANCH_PREDICT;
	logic [31:0]            oNEXT_BRANCH_PREDICT_ADDR;
	logic                   iNEXT_FETCH_STOP;
	logic                   iNEXT_LOCK;
	logic                   iJUMP_STB;
	logic                   iJUMP_TAKEN;
	logic [31:0]            iJUMP_INST_ADDR;
	logic [31:0]            iJUMP_TARGET;

	// Stimulus table, one entry per row
	logic [31:0] row_psr    [NUM_ROWS];
	logic [31:0] row_addr   [NUM_ROWS];	// Restart address, unused by row 0
	int          row_count  [NUM_ROWS];
	logic        row_bp     [NUM_ROWS];	// Random lock inputs
	int          row_jumps  [NUM_ROWS];	// Identical jump updates before the row
	logic        row_taken  [NUM_ROWS];
	logic [31:0] row_jaddr  [NUM_ROWS];
	logic [31:0] row_target [NUM_ROWS];

	// Reference branch table
	logic        ref_valid  [BP_ENTRIES];
	logic [31:0] ref_tag    [BP_ENTRIES];
	logic [1:0]  ref_cnt    [BP_ENTRIES];
	logic [31:0] ref_target [BP_ENTRIES];

	integer seed = 55;
	int     errors = 0;
	int     row_errors = 0;
	int     checks = 0;
	logic   table_ready = 1'b0;

	always #2 iCLOCK = ~iCLOCK;

	fetch_top #(.QUEUE_DEPTH(8), .BP_ENTRIES(BP_ENTRIES)) dut0 (.*);

	bind fetch_top fetch_top_properties props0 (.*);

	function automatic logic is_branch_addr(input logic [31:0] a);
		return a[5:2] == 4'd3;
	endfunction

	// Memory contents as a function of the address
	function automatic logic [31:0] mem_word(input logic [31:0] a);
		logic [9:0]  opcode;
		logic [31:0] word;
		if (is_branch_addr(a))
			opcode = (a[7:6] == 2'd0) ? OC_B : (a[7:6] == 2'd1) ? OC_BR : OC_BUR;
		else
			opcode = {4'b1000, a[7:2]};
		word = {^a, 10'd0, a[22:2]};
		word[OPCODE_MSB:OPCODE_LSB] = opcode;
		return word;
	endfunction

	function automatic logic mem_fault(input logic [31:0] a);
		return a[6] & a[2];
	endfunction

	function automatic logic [MMU_FLAGS_W-1:0] mem_flags(input logic [31:0] a);
		return a[15:2] ^ 14'h2a5;
	endfunction

	function automatic logic expect_predict(input logic [31:0] a);
		logic [IDX_W-1:0] idx;
		idx = a[IDX_W+1:2];
		return is_branch_addr(a) && ref_valid[idx]
			&& (ref_tag[idx] == (a >> (IDX_W + 2))) && (ref_cnt[idx] >= 2'd2);
	endfunction

	task automatic train_ref(input logic [31:0] a, input logic taken, input logic [31:0] tgt);
		logic [IDX_W-1:0] idx;
		idx = a[IDX_W+1:2];
		if (ref_valid[idx] && ref_tag[idx] == (a >> (IDX_W + 2))) begin
			if (taken && ref_cnt[idx] != 2'd3)
				ref_cnt[idx] = ref_cnt[idx] + 2'd1;
			else if (!taken && ref_cnt[idx] != 2'd0)
				ref_cnt[idx] = ref_cnt[idx] - 2'd1;
			if (taken)
				ref_target[idx] = tgt;
		end else begin
			ref_valid[idx]  = 1'b1;	// Allocate
			ref_tag[idx]    = a >> (IDX_W + 2);
			ref_cnt[idx]    = taken ? 2'd2 : 2'd1;
			ref_target[idx] = tgt;
		end
	endtask

	task automatic add_row(input int r, input logic [31:0] psr, input logic [31:0] addr,
		input int count, input logic bp, input int jumps, input logic taken,
		input logic [31:0] jaddr, input logic [31:0] target);
		row_psr[r]    = psr;
		row_addr[r]   = addr;
		row_count[r]  = count;
		row_bp[r]     = bp;
		row_jumps[r]  = jumps;
		row_taken[r]  = taken;
		row_jaddr[r]  = jaddr;
		row_target[r] = target;
	endtask

	task automatic check_signal(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			$display("ERROR t=%0t %s expected %h got %h", $time, name, exp, got);
			row_errors++;
		end
	endtask

	task automatic check_instruction(input logic [31:0] a, input int r);
		logic predict;
		predict = expect_predict(a);
		check_signal("oNEXT_INST", oNEXT_INST, mem_word(a));
		check_signal("oNEXT_PC", oNEXT_PC, a + 32'd4);
		check_signal("oNEXT_PAGEFAULT", 32'(oNEXT_PAGEFAULT), 32'(mem_fault(a)));
		check_signal("oNEXT_MMU_FLAGS", 32'(oNEXT_MMU_FLAGS), 32'(mem_flags(a)));
		check_signal("oNEXT_PAGING_ENA", 32'(oNEXT_PAGING_ENA), 32'(row_psr[r][1:0] != 2'd0));
		check_signal("oNEXT_KERNEL_ACCESS", 32'(oNEXT_KERNEL_ACCESS),
			32'(row_psr[r][6:5] == 2'd0));
		check_signal("oNEXT_BRANCH_PREDICT", 32'(oNEXT_BRANCH_PREDICT), 32'(predict));
		if (predict)
			check_signal("oNEXT_BRANCH_PREDICT_ADDR", oNEXT_BRANCH_PREDICT_ADDR,
				ref_target[a[IDX_W+1:2]]);
	endtask

	// Flush, train the predictor, then restart at the row address
	task automatic restart_fetch(input int r);
		int j;
		@(posedge iCLOCK);
		#1;
		iNEXT_LOCK           = 1'b0;
		iPREVIOUS_FETCH_LOCK = 1'b0;
		iEXCEPTION_EVENT     = 1'b1;
		@(posedge iCLOCK);
		#1;
		iEXCEPTION_EVENT = 1'b0;
		iSYSREG_PSR      = row_psr[r];
		for (j = 0; j < row_jumps[r]; j++) begin
			iJUMP_STB       = 1'b1;
			iJUMP_TAKEN     = row_taken[r];
			iJUMP_INST_ADDR = row_jaddr[r];
			iJUMP_TARGET    = row_target[r];
			train_ref(row_jaddr[r], row_taken[r], row_target[r]);
			@(posedge iCLOCK);
			#1;
		end
		iJUMP_STB           = 1'b0;
		iEXCEPTION_ADDR     = row_addr[r];
		iEXCEPTION_ADDR_SET = 1'b1;
		@(posedge iCLOCK);
		#1;
		iEXCEPTION_ADDR_SET = 1'b0;
	endtask

	// An output is taken on each edge where it is valid and not locked
	task automatic collect_row(input int r);
		logic [31:0] addr;
		int          got;
		addr = (r == 0) ? RESET_VECTOR : {row_addr[r][31:2], 2'b00};
		got  = 0;
		check_signal("oPREVIOUS_MMUMOD", 32'(oPREVIOUS_MMUMOD), 32'(row_psr[r][1:0]));
		while (got < row_count[r]) begin
			@(negedge iCLOCK);
			if (oNEXT_INST_VALID && !iNEXT_LOCK) begin
				check_instruction(addr, r);
				addr = addr + 32'd4;
				got++;
			end
			@(posedge iCLOCK);
			#1;
			if (row_bp[r]) begin
				iNEXT_LOCK           = ($random(seed) & 3) == 0;
				iPREVIOUS_FETCH_LOCK = ($random(seed) & 1) != 0;
			end
		end
	endtask

	// Instruction memory, one cycle latency
	initial begin
		logic        mem_valid;
		logic [31:0] mem_addr;
		mem_valid            = 1'b0;
		mem_addr             = '0;
		iPREVIOUS_INST_VALID = 1'b0;
		iPREVIOUS_INST       = '0;
		iPREVIOUS_PAGEFAULT  = 1'b0;
		iPREVIOUS_MMU_FLAGS  = '0;
		forever begin
			@(negedge iCLOCK);
			if (!inRESET || iEXCEPTION_EVENT) begin
				mem_valid = 1'b0;
			end else if (!oPREVIOUS_LOCK) begin	// Hold while locked
				mem_valid = oPREVIOUS_FETCH_REQ && !iPREVIOUS_FETCH_LOCK;
				mem_addr  = oPREVIOUS_FETCH_ADDR;
			end
			@(posedge iCLOCK);
			#1;
			iPREVIOUS_INST_VALID = mem_valid;
			iPREVIOUS_INST       = mem_valid ? mem_word(mem_addr) : '0;
			iPREVIOUS_PAGEFAULT  = mem_valid && mem_fault(mem_addr);
			iPREVIOUS_MMU_FLAGS  = mem_valid ? mem_flags(mem_addr) : '0;
		end
	end

	initial begin
		int i;
		int longest;
		longest = 0;
		wait (table_ready);
		for (i = 0; i < NUM_ROWS; i++) begin
			if (row_count[i] > longest)
				longest = row_count[i];
		end
		#(NUM_ROWS * longest * 20 * 4);
		$display("Watchdog expired before all rows finished");
		$display("Simulation failed");
		$finish;
	end

	initial begin
		int r;
		add_row(0, 32'h0000_0000, 32'h0000_0000, 20, 1'b0, 0, 1'b0, 32'h0, 32'h0);
		add_row(1, 32'h0000_0003, 32'h0000_0103, 20, 1'b0, 1, 1'b1, 32'h10c, 32'h400);
		add_row(2, 32'h0000_0061, 32'h0000_0100, 24, 1'b1, 0, 1'b0, 32'h0, 32'h0);
		add_row(3, 32'h0000_0020, 32'h0000_0100, 20, 1'b1, 2, 1'b0, 32'h10c, 32'h0);
		add_row(4, 32'h0000_0002, 32'h0000_2001, 24, 1'b1, 2, 1'b1, 32'h204c, 32'h5000);
		for (r = 0; r < BP_ENTRIES; r++) begin
			ref_valid[r]  = 1'b0;
			ref_tag[r]    = '0;
			ref_cnt[r]    = '0;
			ref_target[r] = '0;
		end
		inRESET              = 1'b0;
		iSYSREG_PSR          = row_psr[0];	// Row 0 runs from reset
		iEXCEPTION_EVENT     = 1'b0;
		iEXCEPTION_ADDR_SET  = 1'b0;
		iEXCEPTION_ADDR      = '0;
		iPREVIOUS_FETCH_LOCK = 1'b0;
		iNEXT_FETCH_STOP     = 1'b0;
		iNEXT_LOCK           = 1'b0;
		iJUMP_STB            = 1'b0;
		iJUMP_TAKEN          = 1'b0;
		iJUMP_INST_ADDR      = '0;
		iJUMP_TARGET         = '0;
		table_ready          = 1'b1;
		repeat (5) @(posedge iCLOCK);
		#1;
		inRESET = 1'b1;
		for (r = 0; r < NUM_ROWS; r++) begin
			row_errors = 0;
			if (r != 0)
				restart_fetch(r);
			collect_row(r);
			if (row_errors == 0)
				$display("Row %0d ok, %0d instructions checked", r, row_count[r]);
			else
				$display("Row %0d had %0d mismatches", r, row_errors);
			errors += row_errors;
		end
		errors += dut0.props0.assert_fails;
		$display("Checks %0d, errors %0d, assertion failures %0d", checks, errors,
			dut0.props0.assert_fails);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end
endmodule

//--- fetch_top_properties.sv
// Fetch protocol assertions
`timescale 1ns/1ps

module fetch_top_properties (
	input logic                               iCLOCK,
	input logic                               inRESET,
	input logic                               iEXCEPTION_EVENT,
	input logic                               iNEXT_LOCK,
	input logic                               oPREVIOUS_FETCH_REQ,
	input logic                               oNEXT_INST_VALID,
	input logic [31:0]                        oNEXT_INST,
	input logic [31:0]                        oNEXT_PC,
	input logic [fetch_pkg::MMU_FLAGS_W-1:0]  oNEXT_MMU_FLAGS,
	input logic                               oNEXT_BRANCH_PREDICT
);
	int unsigned assert_fails = 0;

	// Idle in reset and on the first edge after it
	reset_idle: assert property (@(posedge iCLOCK)
		(!inRESET || $rose(inRESET)) |-> (!oNEXT_INST_VALID && !oPREVIOUS_FETCH_REQ))
		else begin
			assert_fails++;
			$error("Request or valid output active around reset");
		end

	no_req_on_event: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		iEXCEPTION_EVENT |-> !oPREVIOUS_FETCH_REQ)
		else begin
			assert_fails++;
			$error("Fetch request issued during an exception event");
		end

	// Decode side holds while locked
	hold_on_lock: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		($past(iNEXT_LOCK) && !$past(iEXCEPTION_EVENT)) |-> ($stable(oNEXT_INST_VALID)
		&& $stable(oNEXT_INST) && $stable(oNEXT_PC) && $stable(oNEXT_MMU_FLAGS)
		&& $stable(oNEXT_BRANCH_PREDICT)))
		else begin
			assert_fails++;
			$error("Outputs changed while the next stage was locked");
		end
endmodule

//--- fetch_top.sv
// Fetch stage top level
`timescale 1ns/1ps

module fetch_top #(
	parameter int unsigned QUEUE_DEPTH = 8,
	parameter int unsigned BP_ENTRIES  = 8
) (
	input  logic                         iCLOCK,
	input  logic                         inRESET,
	input  logic [31:0]                  iSYSREG_PSR,
	input  logic                         iEXCEPTION_EVENT,
	input  logic                         iEXCEPTION_ADDR_SET,
	input  logic [31:0]                  iEXCEPTION_ADDR,
	output logic                         oPREVIOUS_FETCH_REQ,
	input  logic                         iPREVIOUS_FETCH_LOCK,
	output logic [1:0]                   oPREVIOUS_MMUMOD,
	output logic [31:0]                  oPREVIOUS_FETCH_ADDR,
	input  logic                         iPREVIOUS_INST_VALID,
	input  logic [31:0]                  iPREVIOUS_INST,
	input  logic                         iPREVIOUS_PAGEFAULT,
	input  logic [fetch_pkg::MMU_FLAGS_W-1:0] iPREVIOUS_MMU_FLAGS,
	output logic                         oPREVIOUS_LOCK,
	output logic                         oNEXT_INST_VALID,
	output logic [31:0]                  oNEXT_INST,
	output logic                         oNEXT_PAGEFAULT,
	output logic [fetch_pkg::MMU_FLAGS_W-1:0] oNEXT_MMU_FLAGS,
	output logic                         oNEXT_PAGING_ENA,
	output logic                         oNEXT_KERNEL_ACCESS,
	output logic [31:0]                  oNEXT_PC,
	output logic                         oNEXT_BRANCH_PREDICT,
	output logic [31:0]                  oNEXT_BRANCH_PREDICT_ADDR,
	input  logic                         iNEXT_FETCH_STOP,
	input  logic                         iNEXT_LOCK,
	input  logic                         iJUMP_STB,
	input  logic                         iJUMP_TAKEN,
	input  logic [31:0]                  iJUMP_INST_ADDR,
	input  logic [31:0]                  iJUMP_TARGET
);
	bp_if bp0 ();

	fetch #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_fetch (.*, .bp(bp0.requester));

	// Trained by resolved jumps
	branch_predictor #(.BP_ENTRIES(BP_ENTRIES)) u_bp (
		.iCLOCK        (iCLOCK),
		.inRESET       (inRESET),
		.bp            (bp0.responder),
		.jump_stb      (iJUMP_STB),
		.jump_taken    (iJUMP_TAKEN),
		.jump_inst_addr(iJUMP_INST_ADDR),
		.jump_target   (iJUMP_TARGET)
	);
endmodule

//--- fetch.sv
// Instruction fetch stage
`timescale 1ns/1ps

module fetch #(
	parameter int unsigned QUEUE_DEPTH = 8
) (
	input  logic                         iCLOCK,
	input  logic                         inRESET,
	input  logic [31:0]                  iSYSREG_PSR,
	input  logic                         iEXCEPTION_EVENT,
	input  logic                         iEXCEPTION_ADDR_SET,
	input  logic [31:0]                  iEXCEPTION_ADDR,
	output logic                         oPREVIOUS_FETCH_REQ,
	input  logic                         iPREVIOUS_FETCH_LOCK,
	output logic [1:0]                   oPREVIOUS_MMUMOD,
	output logic [31:0]                  oPREVIOUS_FETCH_ADDR,
	input  logic                         iPREVIOUS_INST_VALID,
	input  logic [31:0]                  iPREVIOUS_INST,
	input  logic                         iPREVIOUS_PAGEFAULT,
	input  logic [fetch_pkg::MMU_FLAGS_W-1:0] iPREVIOUS_MMU_FLAGS,
	output logic                         oPREVIOUS_LOCK,
	output logic                         oNEXT_INST_VALID,
	output logic [31:0]                  oNEXT_INST,
	output logic                         oNEXT_PAGEFAULT,
	output logic [fetch_pkg::MMU_FLAGS_W-1:0] oNEXT_MMU_FLAGS,
	output logic                         oNEXT_PAGING_ENA,
	output logic                         oNEXT_KERNEL_ACCESS,
	output logic [31:0]                  oNEXT_PC,
	output logic                         oNEXT_BRANCH_PREDICT,
	output logic [31:0]                  oNEXT_BRANCH_PREDICT_ADDR,
	input  logic                         iNEXT_FETCH_STOP,
	input  logic                         iNEXT_LOCK,
	bp_if.requester                      bp
);
	import core_pkg::*;
	import fetch_pkg::*;

	localparam int unsigned Q_WIDTH = 34;	// Kernel, paging, address

	// PC machine states
	localparam logic [1:0] ST_RESET = 2'd0;
	localparam logic [1:0] ST_FETCH = 2'd1;
	localparam logic [1:0] ST_WAIT  = 2'd2;

	logic [1:0]  state_q;
	logic [31:0] pc_q;
	logic        req_accept;
	logic        paging_ena;
	logic        kernel_access;
	logic        q_full;
	logic        q_empty;
	logic        q_pop;
	logic [31:0] q_addr;
	logic        q_paging;
	logic        q_kernel;
	logic        inst_is_branch;
	logic        next_is_branch_q;

	assign paging_ena    = |iSYSREG_PSR[PSR_MMU_LSB +: PSR_MMU_W];
	assign kernel_access = ~|iSYSREG_PSR[PSR_PRIV_LSB +: PSR_PRIV_W];

	// Request accepted as soon as it is raised
	assign req_accept = (state_q == ST_FETCH) && !iEXCEPTION_EVENT && !q_full
		&& !iPREVIOUS_FETCH_LOCK && !iNEXT_FETCH_STOP && !iNEXT_LOCK;

	assign oPREVIOUS_FETCH_REQ  = req_accept;
	assign oPREVIOUS_FETCH_ADDR = pc_q;
	assign oPREVIOUS_MMUMOD     = iSYSREG_PSR[PSR_MMU_LSB +: PSR_MMU_W];
	assign oPREVIOUS_LOCK       = iNEXT_LOCK;	// Memory holds its response

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state_q <= ST_RESET;
			pc_q    <= RESET_VECTOR;
		end else if (iEXCEPTION_ADDR_SET) begin
			state_q <= ST_FETCH;
			pc_q    <= {iEXCEPTION_ADDR[31:2], 2'b00};
		end else if (iEXCEPTION_EVENT) begin
			state_q <= ST_WAIT;	// Idle until a restart address
		end else begin
			case (state_q)
				ST_RESET: begin
					state_q <= ST_FETCH;
					pc_q    <= RESET_VECTOR;
				end
				ST_FETCH: begin
					if (req_accept)
						pc_q <= pc_q + INST_BYTES;
				end
				default: begin
					state_q <= ST_WAIT;
				end
			endcase
		end
	end

	// Outstanding requests in issue order
	assign q_pop = iPREVIOUS_INST_VALID && !iNEXT_LOCK && !q_empty;

	fetch_queue #(
		.WIDTH(Q_WIDTH),
		.DEPTH(QUEUE_DEPTH)
	) u_queue (
		.iCLOCK (iCLOCK),
		.inRESET(inRESET),
		.flush  (iEXCEPTION_EVENT),
		.wr_en  (req_accept),
		.wr_data({kernel_access, paging_ena, pc_q}),
		.full   (q_full),
		.rd_en  (q_pop),
		.rd_data({q_kernel, q_paging, q_addr}),
		.empty  (q_empty)
	);

	assign inst_is_branch = iPREVIOUS_INST_VALID && is_branch_inst(iPREVIOUS_INST);
	assign bp.search_stb  = inst_is_branch && !iNEXT_LOCK && !iEXCEPTION_EVENT;
	assign bp.search_addr = q_addr;

	// Output register toward decode
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			oNEXT_INST_VALID    <= 1'b0;
			oNEXT_INST          <= '0;
			oNEXT_PAGEFAULT     <= 1'b0;
			oNEXT_MMU_FLAGS     <= '0;
			oNEXT_PAGING_ENA    <= 1'b0;
			oNEXT_KERNEL_ACCESS <= 1'b0;
			oNEXT_PC            <= '0;
			next_is_branch_q    <= 1'b0;
		end else if (iEXCEPTION_EVENT) begin
			oNEXT_INST_VALID    <= 1'b0;	// Flushed with the queue
			oNEXT_INST          <= '0;
			oNEXT_PAGEFAULT     <= 1'b0;
			oNEXT_MMU_FLAGS     <= '0;
			oNEXT_PAGING_ENA    <= 1'b0;
			oNEXT_KERNEL_ACCESS <= 1'b0;
			oNEXT_PC            <= '0;
			next_is_branch_q    <= 1'b0;
		end else if (!iNEXT_LOCK) begin
			oNEXT_INST_VALID    <= iPREVIOUS_INST_VALID;
			oNEXT_INST          <= iPREVIOUS_INST;
			oNEXT_PAGEFAULT     <= iPREVIOUS_PAGEFAULT;
			oNEXT_MMU_FLAGS     <= iPREVIOUS_MMU_FLAGS;
			oNEXT_PAGING_ENA    <= q_paging;
			oNEXT_KERNEL_ACCESS <= q_kernel;
			oNEXT_PC            <= q_addr + INST_BYTES;
			next_is_branch_q    <= inst_is_branch;
		end
	end

	// Predictor answer lines up with the registered instruction
	assign oNEXT_BRANCH_PREDICT      = next_is_branch_q && bp.hit_valid && bp.predict_taken;
	assign oNEXT_BRANCH_PREDICT_ADDR = bp.target;
endmodule

//--- branch_predictor.sv
// Direct-mapped branch target table
`timescale 1ns/1ps

module branch_predictor #(
	parameter int unsigned BP_ENTRIES = 8
) (
	input  logic        iCLOCK,
	input  logic        inRESET,
	bp_if.responder     bp,
	input  logic        jump_stb,
	input  logic        jump_taken,
	input  logic [31:0] jump_inst_addr,
	input  logic [31:0] jump_target
);
	localparam int unsigned IDX_W = $clog2(BP_ENTRIES);
	localparam int unsigned TAG_W = 30 - IDX_W;	// Bits above the index

	logic [BP_ENTRIES-1:0] entry_valid;
	logic [TAG_W-1:0]      entry_tag    [BP_ENTRIES];
	logic [1:0]            entry_cnt    [BP_ENTRIES];
	logic [31:0]           entry_target [BP_ENTRIES];

	logic [IDX_W-1:0] s_idx;
	logic [TAG_W-1:0] s_tag;
	logic             s_hit;
	logic [IDX_W-1:0] u_idx;
	logic [TAG_W-1:0] u_tag;
	logic             u_hit;

	assign s_idx = bp.search_addr[IDX_W+1:2];
	assign s_tag = bp.search_addr[31:IDX_W+2];
	assign s_hit = entry_valid[s_idx] && (entry_tag[s_idx] == s_tag);

	assign u_idx = jump_inst_addr[IDX_W+1:2];
	assign u_tag = jump_inst_addr[31:IDX_W+2];
	assign u_hit = entry_valid[u_idx] && (entry_tag[u_idx] == u_tag);

	// Search result, held until the next strobe
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			bp.hit_valid     <= 1'b0;
			bp.predict_taken <= 1'b0;
			bp.target        <= '0;
		end else if (bp.search_stb) begin
			bp.hit_valid     <= s_hit;
			bp.predict_taken <= entry_cnt[s_idx][1];	// Counter at 2 or 3
			bp.target        <= s_hit ? entry_target[s_idx] : '0;
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET)
			entry_valid <= '0;
		else if (jump_stb)
			entry_valid[u_idx] <= 1'b1;
	end

	// Training from the jump port
	always_ff @(posedge iCLOCK) begin
		if (jump_stb) begin
			if (u_hit) begin
				if (jump_taken && entry_cnt[u_idx] != 2'd3)
					entry_cnt[u_idx] <= entry_cnt[u_idx] + 2'd1;
				else if (!jump_taken && entry_cnt[u_idx] != 2'd0)
					entry_cnt[u_idx] <= entry_cnt[u_idx] - 2'd1;
				if (jump_taken)
					entry_target[u_idx] <= jump_target;
			end else begin
				// Allocate, weakly biased toward the outcome
				entry_tag[u_idx]    <= u_tag;
				entry_cnt[u_idx]    <= jump_taken ? 2'd2 : 2'd1;
				entry_target[u_idx] <= jump_target;
			end
		end
	end
endmodule

//--- fetch_queue.sv
// Flushable fetch address FIFO
`timescale 1ns/1ps

module fetch_queue #(
	parameter int unsigned WIDTH = 34,
	parameter int unsigned DEPTH = 8
) (
	input  logic             iCLOCK,
	input  logic             inRESET,
	input  logic             flush,
	input  logic             wr_en,
	input  logic [WIDTH-1:0] wr_data,
	output logic             full,
	input  logic             rd_en,
	output logic [WIDTH-1:0] rd_data,
	output logic             empty
);
	localparam int unsigned PTR_W = $clog2(DEPTH);
	localparam int unsigned CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_wr;
	logic             do_rd;

	// Wraps also for depths that are not a power of two
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign full    = (count == CNT_W'(DEPTH));
	assign empty   = (count == '0);
	assign do_wr   = wr_en && !full;
	assign do_rd   = rd_en && !empty;
	assign rd_data = mem[rd_ptr];	// Head word, fall-through

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= ptr_inc(wr_ptr);
			if (do_rd)
				rd_ptr <= ptr_inc(rd_ptr);
			count <= count + CNT_W'(do_wr) - CNT_W'(do_rd);
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (do_wr)
			mem[wr_ptr] <= wr_data;
	end
endmodule

//--- bp_if.sv
// Branch predictor search interface
`timescale 1ns/1ps

interface bp_if;
	logic        search_stb;	// One cycle, branch returning
	logic [31:0] search_addr;	// Address of that branch
	logic        hit_valid;
	logic        predict_taken;
	logic [31:0] target;

	modport requester (
		output search_stb, search_addr,
		input  hit_valid, predict_taken, target
	);

	// Answers one cycle after the strobe
	modport responder (
		input  search_stb, search_addr,
		output hit_valid, predict_taken, target
	);
endinterface

//--- fetch_pkg.sv
// Fetch stage constants
package fetch_pkg;

	// PSR layout
	// Bits 1:0 hold the MMU mode, paging on when nonzero
	localparam int unsigned PSR_MMU_LSB  = 0;
	localparam int unsigned PSR_MMU_W    = 2;

	// Bits 6:5 hold the privilege level, zero means kernel
	localparam int unsigned PSR_PRIV_LSB = 5;
	localparam int unsigned PSR_PRIV_W   = 2;

	// MMU flags returned with each instruction
	localparam int unsigned MMU_FLAGS_W  = 14;

	// Address of the first fetch after reset
	localparam logic [31:0] RESET_VECTOR = 32'h0000_0000;

	// Instruction slot size in bytes
	localparam logic [31:0] INST_BYTES   = 32'd4;

endpackage

//--- core_pkg.sv
// Core instruction set constants
package core_pkg;

	// Opcode field inside the 32-bit instruction word
	localparam int unsigned OPCODE_MSB = 30;
	localparam int unsigned OPCODE_LSB = 21;

	// Branch opcodes
	localparam logic [9:0] OC_B   = 10'h062;	// Immediate branch
	localparam logic [9:0] OC_BR  = 10'h061;	// Register branch
	localparam logic [9:0] OC_BUR = 10'h060;	// Unconditional register branch

	// True when the word carries one of the branch opcodes
	function automatic logic is_branch_inst(input logic [31:0] inst);
		logic [9:0] opcode;
		logic       result;
		opcode = inst[OPCODE_MSB:OPCODE_LSB];
		case (opcode)
			OC_B,
			OC_BR,
			OC_BUR: begin
				result = 1'b1;
			end
			default: begin
				result = 1'b0;
			end
		endcase
		return result;
	endfunction

endpackage
